// File: project.f
+incdir+source
source/tscCpuPkg.sv
source/controlDecoder.sv
source/hazardDetector.sv
source/registerFile.sv
source/fetchUnit.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memWbUnit.sv
source/tscCpu.sv
dv/tscCpuTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tscCpuTb -f project.f -o tscCpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tscCpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

// File: dv/tscCpuTb.sv
`timescale 1ns/1ps
`include "tscCpu_macros.svh"

module tscCpuTb import tscCpuPkg::*; ();

    localparam int PROG_LEN     = 53;
    localparam int EXP_CNT      = 13;
    localparam int ST_CNT       = 2;
    localparam int LD_CNT       = 2;
    localparam int RESET_CYCLES = 4;
    // Worst case of five cycles per instruction with an eightfold margin
    localparam int WATCHDOG_CYCLES = PROG_LEN * 5 * 8;
    // r3 holds this on every wrong path
    localparam word_t MARKER = 16'hBA00;

    logic        Clk;
    logic        rstN;
    word_t       instAddr;
    word_t       instData;
    dataMemReq_t dataReq;
    word_t       dataRdata;
    word_t       outPort;
    logic        outValid;
    logic        halted;

    word_t progMem [PROG_LEN];
    word_t dataMem [256];
    word_t expOut [EXP_CNT];
    word_t expStAddr [ST_CNT];
    word_t expStData [ST_CNT];
    word_t expLdAddr [LD_CNT];

    int    errCount = 0;
    int    outIdx   = 0;
    int    stIdx    = 0;
    int    ldIdx    = 0;
    logic  rstQ     = 1'b0;
    logic  haltedQ  = 1'b0;
    word_t addrQ    = '0;

    tscCpu dut (
        .Clk, .i_rstN(rstN),
        .o_instAddr(instAddr), .i_instData(instData),
        .o_dataReq(dataReq), .i_dataRdata(dataRdata),
        .o_outPort(outPort), .o_outValid(outValid), .o_halted(halted)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t rTypeWord(input logic [1:0] rs, rt, rd, input func_e fn);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t iTypeWord(input opcode_e op, input logic [1:0] rs, rt,
                                        input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jTypeWord(input opcode_e op, input logic [11:0] target);
        return {op, target};
    endfunction

    // WWD of one register
    function automatic word_t portWord(input logic [1:0] rs);
        return rTypeWord(rs, 2'd0, 2'd0, FN_WWD);
    endfunction

    // Data memory contents before any store
    function automatic word_t fillWord(input logic [7:0] addr);
        return {addr, ~addr};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////////////////////
    // Past the program every fetch sees HLT
    assign instData = (instAddr < PROG_LEN) ? progMem[instAddr[5:0]]
                                            : rTypeWord(2'd0, 2'd0, 2'd0, FN_HLT);
    assign dataRdata = dataMem[dataReq.addr[7:0]];

    always @(posedge Clk) begin
        if (!rstN) begin
            for (int a = 0; a < 256; a++) begin
                dataMem[a] <= fillWord(a[7:0]);
            end
        end else if (dataReq.write) begin
            dataMem[dataReq.addr[7:0]] <= dataReq.wdata;
        end
    end

    task automatic writeProgram();
        // Dependent chain that leaves r0 = 0x12F4 then r1 = 0x1279 and r2 = 0x007B
        progMem[0]  = iTypeWord(OP_LHI, 2'd0, 2'd0, 8'h12);
        progMem[1]  = iTypeWord(OP_ORI, 2'd0, 2'd0, 8'hF4);
        progMem[2]  = portWord(2'd0);
        progMem[3]  = iTypeWord(OP_ADI, 2'd0, 2'd1, 8'h85);
        progMem[4]  = rTypeWord(2'd0, 2'd1, 2'd2, FN_SUB);
        progMem[5]  = portWord(2'd2);
        progMem[6]  = rTypeWord(2'd0, 2'd2, 2'd3, FN_ADD);
        progMem[7]  = portWord(2'd3);
        progMem[8]  = rTypeWord(2'd0, 2'd1, 2'd3, FN_AND);
        progMem[9]  = portWord(2'd3);
        progMem[10] = rTypeWord(2'd1, 2'd2, 2'd3, FN_ORR);
        progMem[11] = portWord(2'd3);
        progMem[12] = rTypeWord(2'd0, 2'd0, 2'd3, FN_NOT);
        progMem[13] = portWord(2'd3);
        progMem[14] = rTypeWord(2'd2, 2'd0, 2'd3, FN_TCP);
        progMem[15] = portWord(2'd3);
        progMem[16] = rTypeWord(2'd3, 2'd0, 2'd3, FN_SHR);
        progMem[17] = portWord(2'd3);
        progMem[18] = rTypeWord(2'd0, 2'd0, 2'd3, FN_SHL);
        progMem[19] = portWord(2'd3);
        // Store then reload, then a load of untouched memory
        progMem[20] = iTypeWord(OP_SWD, 2'd2, 2'd1, 8'h05);
        progMem[21] = iTypeWord(OP_LWD, 2'd2, 2'd3, 8'h05);
        progMem[22] = portWord(2'd3);
        progMem[23] = iTypeWord(OP_LWD, 2'd2, 2'd0, 8'hF0);
        progMem[24] = portWord(2'd0);
        progMem[25] = iTypeWord(OP_SWD, 2'd1, 2'd0, 8'h87);
        progMem[26] = iTypeWord(OP_LHI, 2'd0, 2'd3, 8'hBA);
        // Taken branch, marker, then a not-taken one that would land on a marker
        progMem[27] = iTypeWord(OP_BNE, 2'd0, 2'd1, 8'd1);
        progMem[28] = portWord(2'd3);
        progMem[29] = iTypeWord(OP_BEQ, 2'd0, 2'd1, 8'd1);
        progMem[30] = iTypeWord(OP_BEQ, 2'd1, 2'd1, 8'd1);
        progMem[31] = portWord(2'd3);
        progMem[32] = iTypeWord(OP_BNE, 2'd2, 2'd2, 8'd1);
        progMem[33] = iTypeWord(OP_BGZ, 2'd0, 2'd0, 8'd1);
        progMem[34] = portWord(2'd3);
        progMem[35] = iTypeWord(OP_BGZ, 2'd3, 2'd0, 8'd1);
        progMem[36] = iTypeWord(OP_BLZ, 2'd3, 2'd0, 8'd1);
        progMem[37] = portWord(2'd3);
        progMem[38] = iTypeWord(OP_BLZ, 2'd0, 2'd0, 8'd1);
        // Jumps
        progMem[39] = jTypeWord(OP_JMP, 12'd41);
        progMem[40] = portWord(2'd3);
        progMem[41] = jTypeWord(OP_JAL, 12'd43);
        progMem[42] = portWord(2'd3);
        progMem[43] = portWord(2'd2);
        progMem[44] = iTypeWord(OP_ADI, 2'd2, 2'd1, 8'd5);
        progMem[45] = rTypeWord(2'd1, 2'd0, 2'd0, FN_JRL);
        progMem[46] = portWord(2'd3);
        progMem[47] = portWord(2'd2);
        progMem[48] = iTypeWord(OP_ADI, 2'd1, 2'd1, 8'd4);
        progMem[49] = rTypeWord(2'd1, 2'd0, 2'd0, FN_JPR);
        progMem[50] = portWord(2'd3);
        progMem[51] = rTypeWord(2'd0, 2'd0, 2'd0, FN_HLT);
        // Must stay silent
        progMem[52] = portWord(2'd0);
    endtask

    task automatic setExpected();
        expOut[0]  = 16'h12F4;
        // 0x12F4 - 0x1279
        expOut[1]  = 16'h007B;
        expOut[2]  = 16'h136F;
        expOut[3]  = 16'h1270;
        expOut[4]  = 16'h127B;
        expOut[5]  = 16'hED0B;
        expOut[6]  = 16'hFF85;
        // Arithmetic shift keeps the sign
        expOut[7]  = 16'hFFC2;
        expOut[8]  = 16'h25E8;
        expOut[9]  = 16'h1279;
        expOut[10] = fillWord(8'h6B);
        // Link addresses of JAL at 41 and JRL at 45
        expOut[11] = 16'h002A;
        expOut[12] = 16'h002E;
        expStAddr[0] = 16'h0080;
        expStData[0] = 16'h1279;
        expStAddr[1] = 16'h1200;
        expStData[1] = fillWord(8'h6B);
        // Reload of the first store, then the untouched word
        expLdAddr[0] = 16'h0080;
        expLdAddr[1] = 16'h006B;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge Clk) begin
        rstQ    <= !rstN;
        haltedQ <= halted && rstN;
        addrQ   <= instAddr;
        if (rstN && outValid) outIdx <= outIdx + 1;
        if (rstN && dataReq.write) stIdx <= stIdx + 1;
        if (rstN && dataReq.read) ldIdx <= ldIdx + 1;
    end

    // Reset cycles and the first cycle after
    assert property (@(posedge Clk) rstQ |-> (!outValid && !halted && !dataReq.read &&
                                               !dataReq.write && instAddr == `RESET_PC))
    else begin
        errCount = errCount + 1;
        $display("Mismatch at %0t: outputs not at reset values", $time);
    end

    assert property (@(posedge Clk) disable iff (!rstN)
                     outValid |-> (outIdx < EXP_CNT && outPort == expOut[outIdx]))
    else begin
        errCount = errCount + 1;
        $display("Mismatch at %0t: output port value or order is wrong", $time);
    end

    assert property (@(posedge Clk) disable iff (!rstN) outValid |-> outPort != MARKER)
    else begin
        errCount = errCount + 1;
        $display("Mismatch at %0t: wrong-path WWD reached the output port", $time);
    end

    assert property (@(posedge Clk) disable iff (!rstN)
                     dataReq.write |-> (stIdx < ST_CNT && dataReq.addr == expStAddr[stIdx] &&
                                        dataReq.wdata == expStData[stIdx]))
    else begin
        errCount = errCount + 1;
        $display("Mismatch at %0t: store address or data is wrong", $time);
    end

    assert property (@(posedge Clk) disable iff (!rstN)
                     dataReq.read |-> (ldIdx < LD_CNT && dataReq.addr == expLdAddr[ldIdx]))
    else begin
        errCount = errCount + 1;
        $display("Mismatch at %0t: load address is wrong", $time);
    end

    // Halt is sticky and freezes fetch
    assert property (@(posedge Clk) disable iff (!rstN)
                     haltedQ |-> (halted && !outValid && instAddr == addrQ))
    else begin
        errCount = errCount + 1;
        $display("Mismatch at %0t: CPU kept running after halt", $time);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Clock, reset, run and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    initial begin
        rstN = 1'b0;
        writeProgram();
        setExpected();
        repeat (RESET_CYCLES) @(posedge Clk);
        #1 rstN = 1'b1;
        // HLT marks the end of the program
        while (!halted) @(negedge Clk);
        // Some cycles to watch the halted state
        repeat (8) @(negedge Clk);
        assert (outIdx == EXP_CNT)
        else begin
            errCount = errCount + 1;
            $display("Mismatch at %0t: %0d outputs reported, %0d expected",
                     $time, outIdx, EXP_CNT);
        end
        assert (stIdx == ST_CNT)
        else begin
            errCount = errCount + 1;
            $display("Mismatch at %0t: %0d stores seen, %0d expected",
                     $time, stIdx, ST_CNT);
        end
        assert (ldIdx == LD_CNT)
        else begin
            errCount = errCount + 1;
            $display("Mismatch at %0t: %0d loads seen, %0d expected",
                     $time, ldIdx, LD_CNT);
        end
        $display("Errors: %0d, outputs %0d of %0d, stores %0d of %0d, loads %0d of %0d",
                 errCount, outIdx, EXP_CNT, stIdx, ST_CNT, ldIdx, LD_CNT);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("Timeout: the CPU did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: source/tscCpu.sv
`timescale 1ns/1ps

module tscCpu import tscCpuPkg::*; (
    input  logic        Clk,
    input  logic        i_rstN,
    output word_t       o_instAddr,
    input  word_t       i_instData,
    output dataMemReq_t o_dataReq,
    input  word_t       i_dataRdata,
    output word_t       o_outPort,
    output logic        o_outValid,
    output logic        o_halted
);

    // IF/ID
    instWord_u ifInst;
    word_t     ifPc;
    word_t     ifPredPc;

    // Redirects and stall
    logic  stall;
    logic  jumpRedirect;
    word_t jumpTarget;
    logic  branchRedirect;
    word_t branchTarget;

    idEx_t  idEx;
    exMem_t exMem;

    // Destinations of ID/EX, EX/MEM and MEM/WB
    destTag_t idTag;
    destTag_t exTag;
    destTag_t wbTag;

    // Write-back port
    logic     wbEn;
    regAddr_t wbAddr;
    word_t    wbData;

    fetchUnit fetch (
        .Clk, .i_rstN, .i_instData,
        .i_stall(stall),
        .i_jumpRedirect(jumpRedirect), .i_jumpTarget(jumpTarget),
        .i_branchRedirect(branchRedirect), .i_branchTarget(branchTarget),
        .o_instAddr, .o_ifInst(ifInst), .o_ifPc(ifPc), .o_ifPredPc(ifPredPc)
    );

    // The tag of a stage register marks the instruction in the next stage
    decodeUnit decode (
        .Clk, .i_rstN,
        .i_ifInst(ifInst), .i_ifPc(ifPc), .i_ifPredPc(ifPredPc),
        .i_branchRedirect(branchRedirect),
        .i_exTag(idTag), .i_memTag(exTag), .i_wbTag(wbTag),
        .i_wbEn(wbEn), .i_wbAddr(wbAddr), .i_wbData(wbData),
        .o_stall(stall), .o_jumpRedirect(jumpRedirect), .o_jumpTarget(jumpTarget),
        .o_idEx(idEx), .o_idTag(idTag),
        .o_outPort, .o_outValid, .o_halted
    );

    executeUnit execute (
        .Clk, .i_rstN, .i_idEx(idEx),
        .o_branchRedirect(branchRedirect), .o_branchTarget(branchTarget),
        .o_exMem(exMem), .o_exTag(exTag)
    );

    memWbUnit memWb (
        .Clk, .i_rstN, .i_exMem(exMem), .i_dataRdata,
        .o_dataReq, .o_wbEn(wbEn), .o_wbAddr(wbAddr), .o_wbData(wbData),
        .o_wbTag(wbTag)
    );

endmodule

// File: source/memWbUnit.sv
`timescale 1ns/1ps

module memWbUnit import tscCpuPkg::*; (
    input  logic        Clk,
    input  logic        i_rstN,
    input  exMem_t      i_exMem,
    input  word_t       i_dataRdata,
    output dataMemReq_t o_dataReq,
    output logic        o_wbEn,
    output regAddr_t    o_wbAddr,
    output word_t       o_wbData,
    output destTag_t    o_wbTag
);

    memWb_t memWb;

    // Address from the ALU, store data from rt
    assign o_dataReq = '{read: i_exMem.memRead, write: i_exMem.memWrite,
                         addr: i_exMem.aluRes, wdata: i_exMem.storeData};

    always_ff @(posedge Clk) begin
        if (!i_rstN) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: i_exMem.regWrite, regSrcMem: i_exMem.regSrcMem,
                       aluRes: i_exMem.aluRes, loadData: i_dataRdata, dest: i_exMem.dest};
        end
    end

    // Write-back select
    assign o_wbEn   = memWb.regWrite;
    assign o_wbAddr = memWb.dest;
    assign o_wbData = memWb.regSrcMem ? memWb.loadData : memWb.aluRes;
    assign o_wbTag  = '{valid: memWb.regWrite, addr: memWb.dest};

endmodule

// File: source/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import tscCpuPkg::*; (
    input  logic     Clk,
    input  logic     i_rstN,
    input  idEx_t    i_idEx,
    output logic     o_branchRedirect,
    output word_t    o_branchTarget,
    output exMem_t   o_exMem,
    output destTag_t o_exTag
);

    word_t opA;
    word_t opB;
    word_t aluOut;
    word_t pcPlusOne;
    logic  taken;

    assign opA = (i_idEx.ctrl.aluSrcA == SRCA_PC) ? i_idEx.pc : i_idEx.rsVal;

    always_comb begin
        case (i_idEx.ctrl.aluSrcB)
            SRCB_IMM: opB = i_idEx.imm;
            SRCB_ONE: opB = word_t'(1);
            default:  opB = i_idEx.rtVal;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (i_idEx.ctrl.aluOp)
            ALU_ADD:   aluOut = opA + opB;
            ALU_SUB:   aluOut = opA - opB;
            ALU_AND:   aluOut = opA & opB;
            ALU_ORR:   aluOut = opA | opB;
            ALU_NOT:   aluOut = ~opA;
            ALU_TCP:   aluOut = ~opA + 1'b1;
            ALU_SHL:   aluOut = opA << 1;
            // Arithmetic shift
            ALU_SHR:   aluOut = {opA[15], opA[15:1]};
            ALU_PASSB: aluOut = opB;
            // Zero when equal
            default:   aluOut = opA ^ opB;
        endcase
    end

    // BNE, BEQ, BGZ, BLZ in opcode order
    always_comb begin
        case (i_idEx.ctrl.brCond)
            2'd0:    taken = (aluOut != '0);
            2'd1:    taken = (aluOut == '0);
            2'd2:    taken = ($signed(i_idEx.rsVal) > 0);
            default: taken = ($signed(i_idEx.rsVal) < 0);
        endcase
    end

    assign pcPlusOne        = i_idEx.pc + 1'b1;
    assign o_branchTarget   = taken ? pcPlusOne + i_idEx.imm : pcPlusOne;
    assign o_branchRedirect = i_idEx.ctrl.isBranch && (o_branchTarget != i_idEx.predPc);

    assign o_exTag = '{valid: o_exMem.regWrite, addr: o_exMem.dest};

    always_ff @(posedge Clk) begin
        if (!i_rstN) begin
            o_exMem <= '0;
        end else begin
            o_exMem <= '{regWrite: i_idEx.ctrl.regWrite, regSrcMem: i_idEx.ctrl.regSrcMem,
                         memRead: i_idEx.ctrl.memRead, memWrite: i_idEx.ctrl.memWrite,
                         aluRes: aluOut, storeData: i_idEx.rtVal, dest: i_idEx.dest};
        end
    end

endmodule

// File: source/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit import tscCpuPkg::*; (
    input  logic      Clk,
    input  logic      i_rstN,
    input  instWord_u i_ifInst,
    input  word_t     i_ifPc,
    input  word_t     i_ifPredPc,
    input  logic      i_branchRedirect,
    input  destTag_t  i_exTag,
    input  destTag_t  i_memTag,
    input  destTag_t  i_wbTag,
    input  logic      i_wbEn,
    input  regAddr_t  i_wbAddr,
    input  word_t     i_wbData,
    output logic      o_stall,
    output logic      o_jumpRedirect,
    output word_t     o_jumpTarget,
    output idEx_t     o_idEx,
    output destTag_t  o_idTag,
    output word_t     o_outPort,
    output logic      o_outValid,
    output logic      o_halted
);

    ctrl_t    ctrl;
    logic     hazard;
    logic     frozen;
    word_t    rsVal;
    word_t    rtVal;
    word_t    imm;
    regAddr_t dest;

    controlDecoder ctrlDec (.i_inst(i_ifInst), .o_ctrl(ctrl));

    hazardDetector hazDet (
        .i_inst(i_ifInst), .i_ctrl(ctrl),
        .i_exTag, .i_memTag, .i_wbTag,
        .o_hazard(hazard)
    );

    registerFile regFile (
        .Clk, .i_rstN,
        .i_rdAddrA(i_ifInst.iType.rs), .i_rdAddrB(i_ifInst.iType.rt),
        .i_wrEn(i_wbEn), .i_wrAddr(i_wbAddr), .i_wrData(i_wbData),
        .o_rdDataA(rsVal), .o_rdDataB(rtVal)
    );

    // HLT in ID/EX stops everything behind it
    assign frozen  = o_halted || o_idEx.ctrl.halt;
    assign o_stall = hazard || frozen;

    ////////////////////////////////////////////////////////////////////////////
    // Jumps and output port
    ////////////////////////////////////////////////////////////////////////////
    // Page of the jump's own PC
    assign o_jumpTarget = ctrl.jumpReg ? rsVal :
                          {i_ifPc[15:12], i_ifInst.jType.target};
    assign o_jumpRedirect = ctrl.isJump && !o_stall && (o_jumpTarget != i_ifPredPc);

    assign o_outPort  = rsVal;
    assign o_outValid = ctrl.openPort && !o_stall && !i_branchRedirect;

    // ORI zero-extends, LHI fills the upper byte
    always_comb begin
        case (i_ifInst.iType.opcode)
            OP_ORI:  imm = {8'h00, i_ifInst.iType.imm};
            OP_LHI:  imm = {i_ifInst.iType.imm, 8'h00};
            default: imm = {{8{i_ifInst.iType.imm[7]}}, i_ifInst.iType.imm};
        endcase
    end

    always_comb begin
        case (ctrl.regDst)
            DST_RD:  dest = i_ifInst.rType.rd;
            DST_R2:  dest = regAddr_t'(2);
            default: dest = i_ifInst.iType.rt;
        endcase
    end

    assign o_idTag = '{valid: o_idEx.ctrl.regWrite, addr: o_idEx.dest};

    always_ff @(posedge Clk) begin
        if (!i_rstN) begin
            o_idEx   <= '0;
            o_halted <= 1'b0;
        end else begin
            if (o_idEx.ctrl.halt) o_halted <= 1'b1;
            // Bubble on a flush or data hazard, hold while halting
            if (i_branchRedirect || (hazard && !frozen)) begin
                o_idEx <= '0;
            end else if (!frozen) begin
                o_idEx <= '{ctrl: ctrl, pc: i_ifPc, predPc: i_ifPredPc,
                            rsVal: rsVal, rtVal: rtVal, imm: imm, dest: dest};
            end
        end
    end

endmodule

// File: source/fetchUnit.sv
`timescale 1ns/1ps
`include "tscCpu_macros.svh"

module fetchUnit import tscCpuPkg::*; (
    input  logic      Clk,
    input  logic      i_rstN,
    input  word_t     i_instData,
    input  logic      i_stall,
    input  logic      i_jumpRedirect,
    input  word_t     i_jumpTarget,
    input  logic      i_branchRedirect,
    input  word_t     i_branchTarget,
    output word_t     o_instAddr,
    output instWord_u o_ifInst,
    output word_t     o_ifPc,
    output word_t     o_ifPredPc
);

    word_t pc;
    word_t pcPlusOne;
    word_t nextPc;

    assign o_instAddr = pc;
    // Static prediction
    assign pcPlusOne = pc + 1'b1;

    // Branch is older than the jump and than the stalled instruction
    always_comb begin
        if (i_branchRedirect) nextPc = i_branchTarget;
        else if (i_stall) nextPc = pc;
        else if (i_jumpRedirect) nextPc = i_jumpTarget;
        else nextPc = pcPlusOne;
    end

    always_ff @(posedge Clk) begin
        if (!i_rstN) begin
            pc         <= `RESET_PC;
            o_ifInst   <= `FLUSH_INST;
            o_ifPc     <= '0;
            o_ifPredPc <= '0;
        end else begin
            pc <= nextPc;
            if (i_branchRedirect || i_jumpRedirect) begin
                o_ifInst <= `FLUSH_INST;
            end else if (!i_stall) begin
                o_ifInst   <= i_instData;
                o_ifPc     <= pc;
                o_ifPredPc <= pcPlusOne;
            end
        end
    end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps
`include "tscCpu_macros.svh"

module registerFile import tscCpuPkg::*; (
    input  logic     Clk,
    input  logic     i_rstN,
    input  regAddr_t i_rdAddrA,
    input  regAddr_t i_rdAddrB,
    input  logic     i_wrEn,
    input  regAddr_t i_wrAddr,
    input  word_t    i_wrData,
    output word_t    o_rdDataA,
    output word_t    o_rdDataB
);

    word_t regs [`REG_CNT];

    // No write-through as decode waits out the write-back cycle
    assign o_rdDataA = regs[i_rdAddrA];
    assign o_rdDataB = regs[i_rdAddrB];

    always_ff @(posedge Clk) begin
        if (!i_rstN) regs <= '{default: '0};
        else if (i_wrEn) regs[i_wrAddr] <= i_wrData;
    end

endmodule

// File: source/hazardDetector.sv
`timescale 1ns/1ps

module hazardDetector import tscCpuPkg::*; (
    input  instWord_u i_inst,
    input  ctrl_t     i_ctrl,
    input  destTag_t  i_exTag,
    input  destTag_t  i_memTag,
    input  destTag_t  i_wbTag,
    output logic      o_hazard
);

    logic readsRs;
    logic readsRt;
    logic rsBusy;
    logic rtBusy;

    // Sources actually read, so a bubble never stalls
    assign readsRs = i_ctrl.jumpReg || i_ctrl.openPort || i_ctrl.isBranch ||
                     i_ctrl.memRead || i_ctrl.memWrite ||
                     (i_ctrl.regWrite && i_ctrl.aluSrcA == SRCA_RS &&
                      i_ctrl.aluOp != ALU_PASSB);
    // BGZ and BLZ test rs alone; unary ops ignore rt
    assign readsRt = i_ctrl.memWrite || (i_ctrl.isBranch && !i_ctrl.brCond[1]) ||
                     (i_ctrl.regWrite && i_ctrl.aluSrcB == SRCB_RT &&
                      i_ctrl.aluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR});

    // Any valid in-flight destination
    assign rsBusy = (i_exTag.valid && i_exTag.addr == i_inst.rType.rs) ||
                    (i_memTag.valid && i_memTag.addr == i_inst.rType.rs) ||
                    (i_wbTag.valid && i_wbTag.addr == i_inst.rType.rs);
    assign rtBusy = (i_exTag.valid && i_exTag.addr == i_inst.rType.rt) ||
                    (i_memTag.valid && i_memTag.addr == i_inst.rType.rt) ||
                    (i_wbTag.valid && i_wbTag.addr == i_inst.rType.rt);

    assign o_hazard = (readsRs && rsBusy) || (readsRt && rtBusy);

endmodule

// File: source/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import tscCpuPkg::*; (
    input  instWord_u i_inst,
    output ctrl_t     o_ctrl
);

    always_comb begin
        // Flush word and unknown encodings fall through as all zero
        o_ctrl = '0;
        case (i_inst.rType.opcode)
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
                o_ctrl.isBranch = 1'b1;
                o_ctrl.aluSrcB  = SRCB_RT;
                o_ctrl.aluOp    = ALU_CMP;
                o_ctrl.brCond   = i_inst.rType.opcode[1:0];
            end
            OP_ADI, OP_ORI, OP_LHI: begin
                o_ctrl.regWrite = 1'b1;
                o_ctrl.aluSrcB  = SRCB_IMM;
                o_ctrl.regDst   = DST_RT;
                if (i_inst.rType.opcode == OP_ADI) o_ctrl.aluOp = ALU_ADD;
                else if (i_inst.rType.opcode == OP_ORI) o_ctrl.aluOp = ALU_ORR;
                else o_ctrl.aluOp = ALU_PASSB;
            end
            // Address is rs plus immediate
            OP_LWD: begin
                o_ctrl.regWrite  = 1'b1;
                o_ctrl.memRead   = 1'b1;
                o_ctrl.regSrcMem = 1'b1;
                o_ctrl.aluSrcB   = SRCB_IMM;
                o_ctrl.aluOp     = ALU_ADD;
                o_ctrl.regDst    = DST_RT;
            end
            OP_SWD: begin
                o_ctrl.memWrite = 1'b1;
                o_ctrl.aluSrcB  = SRCB_IMM;
                o_ctrl.aluOp    = ALU_ADD;
            end
            OP_JMP: o_ctrl.isJump = 1'b1;
            OP_JAL: begin
                o_ctrl.isJump = 1'b1;
                o_ctrl.link   = 1'b1;
            end
            OP_RTYPE: begin
                case (i_inst.rType.func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        o_ctrl.regWrite = 1'b1;
                        o_ctrl.aluSrcB  = SRCB_RT;
                        o_ctrl.regDst   = DST_RD;
                        o_ctrl.aluOp    = aluOp_e'(i_inst.rType.func[3:0]);
                    end
                    FN_JPR: begin
                        o_ctrl.isJump  = 1'b1;
                        o_ctrl.jumpReg = 1'b1;
                    end
                    FN_JRL: begin
                        o_ctrl.isJump  = 1'b1;
                        o_ctrl.jumpReg = 1'b1;
                        o_ctrl.link    = 1'b1;
                    end
                    FN_WWD: o_ctrl.openPort = 1'b1;
                    FN_HLT: o_ctrl.halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase

        // Link writes PC+1 into r2
        if (o_ctrl.link) begin
            o_ctrl.regWrite = 1'b1;
            o_ctrl.aluSrcA  = SRCA_PC;
            o_ctrl.aluSrcB  = SRCB_ONE;
            o_ctrl.aluOp    = ALU_ADD;
            o_ctrl.regDst   = DST_R2;
        end
    end

endmodule

// File: source/tscCpuPkg.sv
`include "tscCpu_macros.svh"

package tscCpuPkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [$clog2(`REG_CNT)-1:0] regAddr_t;

    typedef enum logic [3:0] {
        OP_BNE = 4'd0, OP_BEQ = 4'd1, OP_BGZ = 4'd2, OP_BLZ = 4'd3,
        OP_ADI = 4'd4, OP_ORI = 4'd5, OP_LHI = 4'd6, OP_LWD = 4'd7,
        OP_SWD = 4'd8, OP_JMP = 4'd9, OP_JAL = 4'd10, OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0, FN_SUB = 6'd1, FN_AND = 6'd2, FN_ORR = 6'd3,
        FN_NOT = 6'd4, FN_TCP = 6'd5, FN_SHL = 6'd6, FN_SHR = 6'd7,
        FN_JPR = 6'd25, FN_JRL = 6'd26, FN_WWD = 6'd28, FN_HLT = 6'd29
    } func_e;

    // Three views of one instruction word
    typedef struct packed {
        opcode_e  opcode;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        func_e    func;
    } rType_t;

    typedef struct packed {
        opcode_e    opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        logic [7:0] imm;
    } iType_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] target;
    } jType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        jType_t jType;
    } instWord_u;

    // First eight match the R-type function codes
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_PASSB, ALU_CMP
    } aluOp_e;

    typedef enum logic {SRCA_RS, SRCA_PC} aluSrcA_e;
    typedef enum logic [1:0] {SRCB_RT, SRCB_IMM, SRCB_ONE} aluSrcB_e;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_R2} regDst_e;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     regSrcMem;
        logic     isBranch;
        logic     isJump;
        logic     jumpReg;
        logic     link;
        logic     openPort;
        logic     halt;
        aluSrcA_e aluSrcA;
        aluSrcB_e aluSrcB;
        regDst_e  regDst;
        aluOp_e   aluOp;
        // Low opcode bits of a branch
        logic [1:0] brCond;
    } ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    predPc;
        word_t    rsVal;
        word_t    rtVal;
        word_t    imm;
        regAddr_t dest;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     regSrcMem;
        logic     memRead;
        logic     memWrite;
        word_t    aluRes;
        word_t    storeData;
        regAddr_t dest;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     regSrcMem;
        word_t    aluRes;
        word_t    loadData;
        regAddr_t dest;
    } memWb_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } dataMemReq_t;

    // Destination of one in-flight instruction
    typedef struct packed {
        logic     valid;
        regAddr_t addr;
    } destTag_t;

endpackage

// File: source/tscCpu_macros.svh
`ifndef TSCCPU_MACROS_SVH
`define TSCCPU_MACROS_SVH

// Data and address width
`define WORD_W 16

// General registers
`define REG_CNT 4

// First fetch address after reset
`define RESET_PC 16'h0000

// Loaded into IF/ID on a flush
// Opcode 15 with an unused function code, so it decodes to no effect
`define FLUSH_INST 16'hFFFF

`endif
